// File: src/fft_ctrl_config.svh
`ifndef FFT_CTRL_CONFIG_SVH
`define FFT_CTRL_CONFIG_SVH

// log2 of the transform size, every width follows from it
`define FFT_LOG2N 4

// butterfly descriptors held between producer and memory port
`define FFT_DESC_DEPTH 4

// cycles from a read cycle to its write-back enable
`define FFT_WB_DELAY 3

`endif

// File: src/fft_ctrl_pkg.sv
`include "fft_ctrl_config.svh"

package fft_ctrl_pkg;

    // word address into the in-place data memory
    typedef logic [`FFT_LOG2N-1:0] addr_t;

    // twiddle index in steps of 2*pi/N, only the first half circle is used
    typedef logic [`FFT_LOG2N-2:0] twiddle_t;

    typedef logic [$clog2(`FFT_LOG2N)-1:0] stage_t;
    typedef logic [`FFT_LOG2N-2:0] bfly_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT_ACK,
        SEQ_DRAIN
    } seq_state_t;

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_READ_A,
        PORT_READ_B
    } port_state_t;

    typedef enum logic [1:0] {
        UL_IDLE,
        UL_REQ_UP,
        UL_WAIT_DROP,
        UL_DONE
    } unload_state_t;

endpackage

// File: src/fft_bfly_sequencer.sv
`timescale 1ns/1ps
`include "fft_ctrl_config.svh"

module fft_bfly_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    output logic                   busy,
    output logic                   desc_req,
    input  logic                   desc_ack,
    output fft_ctrl_pkg::addr_t    desc_a,
    output fft_ctrl_pkg::addr_t    desc_b,
    output fft_ctrl_pkg::twiddle_t desc_twiddle,
    output logic                   desc_last
);

    localparam fft_ctrl_pkg::stage_t LAST_STAGE = fft_ctrl_pkg::stage_t'(`FFT_LOG2N - 1);
    localparam fft_ctrl_pkg::bfly_t  LAST_BFLY  = '1;

    fft_ctrl_pkg::seq_state_t state;
    fft_ctrl_pkg::stage_t     stage;
    fft_ctrl_pkg::bfly_t      bfly;

    fft_ctrl_pkg::addr_t span;
    fft_ctrl_pkg::addr_t k;
    fft_ctrl_pkg::addr_t group_x2;

    // ----------------------------------------
    // butterfly address rule
    // ----------------------------------------

    // k is the position inside a group, the group index gets scaled by 2*span
    always_comb
    begin
        span         = fft_ctrl_pkg::addr_t'(1) << stage;
        k            = fft_ctrl_pkg::addr_t'(bfly) & (span - 1'b1);
        group_x2     = (fft_ctrl_pkg::addr_t'(bfly) >> stage) << 1;
        desc_a       = (group_x2 << stage) | k;
        desc_b       = desc_a + span;
        // k*(N/2)/span, a plain shift since span is a power of two
        desc_twiddle = fft_ctrl_pkg::twiddle_t'(k) << (`FFT_LOG2N - 1 - stage);
    end

    assign desc_last = (stage == LAST_STAGE) && (bfly == LAST_BFLY);
    assign busy      = (state != fft_ctrl_pkg::SEQ_IDLE);

    // ----------------------------------------
    // descriptor handshake and counters
    // ----------------------------------------

    // issue raises req, wait_ack waits for ack high,
    // drain waits for ack low before the counters move on
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= fft_ctrl_pkg::SEQ_IDLE;
            stage    <= '0;
            bfly     <= '0;
            desc_req <= 1'b0;
        end
        else
        begin
            case (state)
                fft_ctrl_pkg::SEQ_IDLE:
                begin
                    if (start)
                    begin
                        stage <= '0;
                        bfly  <= '0;
                        state <= fft_ctrl_pkg::SEQ_ISSUE;
                    end
                end
                fft_ctrl_pkg::SEQ_ISSUE:
                begin
                    desc_req <= 1'b1;
                    state    <= fft_ctrl_pkg::SEQ_WAIT_ACK;
                end
                fft_ctrl_pkg::SEQ_WAIT_ACK:
                begin
                    if (desc_ack)
                    begin
                        desc_req <= 1'b0;
                        state    <= fft_ctrl_pkg::SEQ_DRAIN;
                    end
                end
                fft_ctrl_pkg::SEQ_DRAIN:
                begin
                    if (!desc_ack)
                    begin
                        if (desc_last)
                        begin
                            state <= fft_ctrl_pkg::SEQ_IDLE;
                        end
                        else
                        begin
                            state <= fft_ctrl_pkg::SEQ_ISSUE;
                            // inner loop over j, stage steps when j wraps
                            if (bfly == LAST_BFLY)
                            begin
                                bfly  <= '0;
                                stage <= stage + 1'b1;
                            end
                            else
                            begin
                                bfly <= bfly + 1'b1;
                            end
                        end
                    end
                end
                default:
                begin
                    state <= fft_ctrl_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/fft_desc_fifo.sv
`timescale 1ns/1ps
`include "fft_ctrl_config.svh"

module fft_desc_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_req,
    output logic                   in_ack,
    input  fft_ctrl_pkg::addr_t    in_a,
    input  fft_ctrl_pkg::addr_t    in_b,
    input  fft_ctrl_pkg::twiddle_t in_twiddle,
    input  logic                   in_last,
    output logic                   out_req,
    input  logic                   out_ack,
    output fft_ctrl_pkg::addr_t    out_a,
    output fft_ctrl_pkg::addr_t    out_b,
    output fft_ctrl_pkg::twiddle_t out_twiddle,
    output logic                   out_last
);

    localparam int DEPTH = `FFT_DESC_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fft_ctrl_pkg::addr_t    mem_a    [DEPTH];
    fft_ctrl_pkg::addr_t    mem_b    [DEPTH];
    fft_ctrl_pkg::twiddle_t mem_tw   [DEPTH];
    logic                   mem_last [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // take a new entry only on a fresh req and only with room left
    assign push = in_req && !in_ack && (count != CNT_W'(DEPTH));
    // the consumer has taken the head entry
    assign pop  = out_req && out_ack;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem_a[wr_ptr]    <= in_a;
            mem_b[wr_ptr]    <= in_b;
            mem_tw[wr_ptr]   <= in_twiddle;
            mem_last[wr_ptr] <= in_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);

            if (push)
            begin
                in_ack <= 1'b1;
            end
            else if (in_ack && !in_req)
            begin
                in_ack <= 1'b0;
            end

            // next req waits until the previous ack has dropped
            if (pop)
            begin
                out_req <= 1'b0;
            end
            else if (!out_req && !out_ack && (count != '0))
            begin
                out_req <= 1'b1;
            end
        end
    end

    assign out_a       = mem_a[rd_ptr];
    assign out_b       = mem_b[rd_ptr];
    assign out_twiddle = mem_tw[rd_ptr];
    assign out_last    = mem_last[rd_ptr];

endmodule

// File: src/fft_mem_port.sv
`timescale 1ns/1ps
`include "fft_ctrl_config.svh"

module fft_mem_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   desc_req,
    output logic                   desc_ack,
    input  fft_ctrl_pkg::addr_t    desc_a,
    input  fft_ctrl_pkg::addr_t    desc_b,
    input  fft_ctrl_pkg::twiddle_t desc_twiddle,
    input  logic                   desc_last,
    output logic                   rd_en,
    output fft_ctrl_pkg::addr_t    rd_addr,
    output fft_ctrl_pkg::twiddle_t rd_twiddle,
    output logic                   wr_en,
    output logic                   finish
);

    localparam int WB_DELAY = `FFT_WB_DELAY;

    fft_ctrl_pkg::port_state_t state;

    fft_ctrl_pkg::addr_t    cur_a;
    fft_ctrl_pkg::addr_t    cur_b;
    fft_ctrl_pkg::twiddle_t cur_tw;
    logic                   cur_last;

    logic                accept;
    logic [WB_DELAY-1:0] wb_pipe;

    // a descriptor is taken only between butterflies
    assign accept = (state == fft_ctrl_pkg::PORT_IDLE) && desc_req && !desc_ack;

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cur_a    <= desc_a;
            cur_b    <= desc_b;
            cur_tw   <= desc_twiddle;
            cur_last <= desc_last;
        end
    end

    // ----------------------------------------
    // read sequence
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= fft_ctrl_pkg::PORT_IDLE;
            desc_ack <= 1'b0;
            finish   <= 1'b0;
        end
        else
        begin
            case (state)
                fft_ctrl_pkg::PORT_IDLE:
                begin
                    if (accept)
                    begin
                        state <= fft_ctrl_pkg::PORT_READ_A;
                    end
                end
                fft_ctrl_pkg::PORT_READ_A:
                begin
                    state <= fft_ctrl_pkg::PORT_READ_B;
                end
                default:
                begin
                    state <= fft_ctrl_pkg::PORT_IDLE;
                end
            endcase

            if (accept)
            begin
                desc_ack <= 1'b1;
            end
            else if (desc_ack && !desc_req)
            begin
                desc_ack <= 1'b0;
            end

            // one cycle after the last addr_b read
            finish <= (state == fft_ctrl_pkg::PORT_READ_B) && cur_last;
        end
    end

    assign rd_en      = (state == fft_ctrl_pkg::PORT_READ_A) ||
                        (state == fft_ctrl_pkg::PORT_READ_B);
    assign rd_addr    = (state == fft_ctrl_pkg::PORT_READ_B) ? cur_b : cur_a;
    assign rd_twiddle = cur_tw;

    // ----------------------------------------
    // write-back enable delay line
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_pipe <= '0;
        end
        else
        begin
            wb_pipe[0] <= rd_en;
            for (int i = 1; i < WB_DELAY; i++)
            begin
                wb_pipe[i] <= wb_pipe[i-1];
            end
        end
    end

    assign wr_en = wb_pipe[WB_DELAY-1];

endmodule

// File: src/fft_unload_seq.sv
`timescale 1ns/1ps
`include "fft_ctrl_config.svh"

module fft_unload_seq (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                finish,
    output logic                out_req,
    input  logic                out_ack,
    output fft_ctrl_pkg::addr_t out_addr,
    output logic                done,
    output logic                active
);

    // all ones is N-1, the final result address
    localparam fft_ctrl_pkg::addr_t LAST_ADDR = '1;

    fft_ctrl_pkg::unload_state_t state;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= fft_ctrl_pkg::UL_IDLE;
            out_req  <= 1'b0;
            out_addr <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                fft_ctrl_pkg::UL_REQ_UP:
                begin
                    if (out_ack)
                    begin
                        out_req <= 1'b0;
                        state   <= fft_ctrl_pkg::UL_WAIT_DROP;
                    end
                end
                fft_ctrl_pkg::UL_WAIT_DROP:
                begin
                    // pace is set by the consumer dropping ack
                    if (!out_ack)
                    begin
                        if (out_addr == LAST_ADDR)
                        begin
                            done  <= 1'b1;
                            state <= fft_ctrl_pkg::UL_DONE;
                        end
                        else
                        begin
                            out_addr <= out_addr + 1'b1;
                            out_req  <= 1'b1;
                            state    <= fft_ctrl_pkg::UL_REQ_UP;
                        end
                    end
                end
                default:
                begin
                    // idle and done both wait for the next finish
                    if (finish)
                    begin
                        out_addr <= '0;
                        out_req  <= 1'b1;
                        state    <= fft_ctrl_pkg::UL_REQ_UP;
                    end
                end
            endcase
        end
    end

    assign active = (state == fft_ctrl_pkg::UL_REQ_UP) ||
                    (state == fft_ctrl_pkg::UL_WAIT_DROP);

endmodule

// File: src/fft_addr_ctrl_top.sv
`timescale 1ns/1ps
`include "fft_ctrl_config.svh"

module fft_addr_ctrl_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    output logic                   rd_en,
    output fft_ctrl_pkg::addr_t    rd_addr,
    output fft_ctrl_pkg::twiddle_t rd_twiddle,
    output logic                   wr_en,
    output logic                   finish,
    output logic                   out_req,
    input  logic                   out_ack,
    output fft_ctrl_pkg::addr_t    out_addr,
    output logic                   done
);

    // producer to buffer
    logic                   desc_req;
    logic                   desc_ack;
    fft_ctrl_pkg::addr_t    desc_a;
    fft_ctrl_pkg::addr_t    desc_b;
    fft_ctrl_pkg::twiddle_t desc_twiddle;
    logic                   desc_last;

    // buffer to memory port
    logic                   port_req;
    logic                   port_ack;
    fft_ctrl_pkg::addr_t    port_a;
    fft_ctrl_pkg::addr_t    port_b;
    fft_ctrl_pkg::twiddle_t port_twiddle;
    logic                   port_last;

    logic busy;
    logic unload_active;
    logic start_ok;

    // no new transform while one is computing or unloading
    assign start_ok = start && !busy && !unload_active;

    fft_bfly_sequencer i_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start_ok),
        .busy         (busy),
        .desc_req     (desc_req),
        .desc_ack     (desc_ack),
        .desc_a       (desc_a),
        .desc_b       (desc_b),
        .desc_twiddle (desc_twiddle),
        .desc_last    (desc_last)
    );

    fft_desc_fifo i_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_req      (desc_req),
        .in_ack      (desc_ack),
        .in_a        (desc_a),
        .in_b        (desc_b),
        .in_twiddle  (desc_twiddle),
        .in_last     (desc_last),
        .out_req     (port_req),
        .out_ack     (port_ack),
        .out_a       (port_a),
        .out_b       (port_b),
        .out_twiddle (port_twiddle),
        .out_last    (port_last)
    );

    fft_mem_port i_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .desc_req     (port_req),
        .desc_ack     (port_ack),
        .desc_a       (port_a),
        .desc_b       (port_b),
        .desc_twiddle (port_twiddle),
        .desc_last    (port_last),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_twiddle   (rd_twiddle),
        .wr_en        (wr_en),
        .finish       (finish)
    );

    fft_unload_seq i_unload (
        .clk      (clk),
        .rst_n    (rst_n),
        .finish   (finish),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_addr (out_addr),
        .done     (done),
        .active   (unload_active)
    );

endmodule

// File: dv/fft_addr_ctrl_tb.sv
`timescale 1ns/1ps
`include "fft_ctrl_config.svh"

module fft_addr_ctrl_tb;

    localparam int N        = 1 << `FFT_LOG2N;
    localparam int NREADS   = N * `FFT_LOG2N;
    localparam int WAIT_MAX = 1000;

    // selectors for the level wait loop
    localparam int SIG_RD_EN   = 0;
    localparam int SIG_FINISH  = 1;
    localparam int SIG_OUT_REQ = 2;
    localparam int SIG_DONE    = 3;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   start;
    logic                   rd_en;
    fft_ctrl_pkg::addr_t    rd_addr;
    fft_ctrl_pkg::twiddle_t rd_twiddle;
    logic                   wr_en;
    logic                   finish;
    logic                   out_req;
    logic                   out_ack;
    fft_ctrl_pkg::addr_t    out_addr;
    logic                   done;

    int cycle;
    int checks;
    int errors;
    int done_cnt;
    bit aborted;

    fft_ctrl_pkg::addr_t    rd_addr_q [$];
    fft_ctrl_pkg::twiddle_t rd_tw_q   [$];
    int                     rd_cyc_q  [$];
    int                     wr_cyc_q  [$];
    int                     fin_cyc_q [$];

    fft_addr_ctrl_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_twiddle (rd_twiddle),
        .wr_en      (wr_en),
        .finish     (finish),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_addr   (out_addr),
        .done       (done)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // stops the run after a timeout
    always @(posedge aborted)
    begin
        $finish;
    end

    // ----------------------------------------
    // monitor sampling outputs mid-cycle
    // ----------------------------------------

    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (rd_en)
            begin
                rd_addr_q.push_back(rd_addr);
                rd_tw_q.push_back(rd_twiddle);
                rd_cyc_q.push_back(cycle);
            end
            if (wr_en)
            begin
                wr_cyc_q.push_back(cycle);
            end
            if (finish)
            begin
                fin_cyc_q.push_back(cycle);
            end
            if (done)
            begin
                done_cnt++;
            end
        end
    end

    // ----------------------------------------
    // compare and wait helpers
    // ----------------------------------------

    task automatic check_addr(input string name, input string what,
                              input fft_ctrl_pkg::addr_t exp, input fft_ctrl_pkg::addr_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("error %s %s: expected %0d, actual %0d", name, what, exp, act);
        end
    endtask

    task automatic check_twiddle(input string name, input string what,
                                 input fft_ctrl_pkg::twiddle_t exp,
                                 input fft_ctrl_pkg::twiddle_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("error %s %s: expected %0d, actual %0d", name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("error %s %s: expected %b, actual %b", name, what, exp, act);
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp, input int act);
        checks++;
        if (act != exp)
        begin
            errors++;
            $display("error %s %s: expected %0d, actual %0d", name, what, exp, act);
        end
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            SIG_RD_EN:   return rd_en;
            SIG_FINISH:  return finish;
            SIG_OUT_REQ: return out_req;
            default:     return done;
        endcase
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout, %s did not arrive within %0d cycles", what, WAIT_MAX);
        $display("Checks failed");
        aborted = 1'b1;
        wait (!aborted);
    endtask

    // entered on a falling edge and left on the falling edge that shows the level
    task automatic wait_level(input int sel, input logic level, input string what);
        int n;
        n = 0;
        while (probe(sel) !== level && n < WAIT_MAX)
        begin
            @(negedge clk);
            n++;
        end
        if (probe(sel) !== level)
        begin
            report_timeout(what);
        end
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------

    task automatic test_reset_state();
        int err_before;
        err_before = errors;
        repeat (20)
        begin
            @(negedge clk);
            check_flag("reset_state", "rd_en", 1'b0, rd_en);
            check_flag("reset_state", "wr_en", 1'b0, wr_en);
            check_flag("reset_state", "finish", 1'b0, finish);
            check_flag("reset_state", "out_req", 1'b0, out_req);
            check_flag("reset_state", "done", 1'b0, done);
        end
        report_test("reset_state", err_before);
    endtask

    // one full transform with compute and unload
    // poke adds start pulses that must be ignored
    task automatic run_transform(input string name, input bit poke);
        int err_before;
        int rd0;
        int wr0;
        int fin0;
        int done0;
        int n;
        int idx;
        int span;
        int k;
        int a;
        int tw;
        int delay;
        err_before = errors;
        rd0        = rd_cyc_q.size();
        wr0        = wr_cyc_q.size();
        fin0       = fin_cyc_q.size();
        done0      = done_cnt;
        pulse_start();
        if (poke)
        begin
            wait_level(SIG_RD_EN, 1'b1, "first rd_en");
            pulse_start();
        end
        wait_level(SIG_FINISH, 1'b1, "finish");

        // the last write-back trails finish
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end
        while ((wr_cyc_q.size() - wr0 != rd_cyc_q.size() - rd0) && n < WAIT_MAX);
        if (wr_cyc_q.size() - wr0 != rd_cyc_q.size() - rd0)
        begin
            report_timeout("a write-back enable for every read");
        end

        check_count(name, "reads", NREADS, rd_cyc_q.size() - rd0);
        check_count(name, "finish pulses", 1, fin_cyc_q.size() - fin0);
        for (int i = 0; i < wr_cyc_q.size() - wr0; i++)
        begin
            check_count(name, "write-back cycle", rd_cyc_q[rd0 + i] + `FFT_WB_DELAY,
                        wr_cyc_q[wr0 + i]);
        end
        if (rd_cyc_q.size() - rd0 == NREADS)
        begin
            idx = rd0;
            for (int s = 0; s < `FFT_LOG2N; s++)
            begin
                for (int j = 0; j < N / 2; j++)
                begin
                    span = 1 << s;
                    k    = j % span;
                    a    = (j / span) * 2 * span + k;
                    tw   = k * (N / 2) / span;
                    check_addr(name, "addr_a", fft_ctrl_pkg::addr_t'(a), rd_addr_q[idx]);
                    check_addr(name, "addr_b", fft_ctrl_pkg::addr_t'(a + span),
                               rd_addr_q[idx + 1]);
                    check_twiddle(name, "twiddle a", fft_ctrl_pkg::twiddle_t'(tw), rd_tw_q[idx]);
                    check_twiddle(name, "twiddle b", fft_ctrl_pkg::twiddle_t'(tw),
                                  rd_tw_q[idx + 1]);
                    check_count(name, "read pair spacing", rd_cyc_q[idx] + 1, rd_cyc_q[idx + 1]);
                    idx += 2;
                end
            end
            if (fin_cyc_q.size() - fin0 == 1)
            begin
                check_count(name, "finish cycle", rd_cyc_q[rd0 + NREADS - 1] + 1, fin_cyc_q[fin0]);
            end
        end

        // unload with the testbench as consumer and random ack delays
        @(negedge clk);
        for (int i = 0; i < N; i++)
        begin
            wait_level(SIG_OUT_REQ, 1'b1, "out_req");
            check_addr(name, "out_addr", fft_ctrl_pkg::addr_t'(i), out_addr);
            if (poke && i == 2)
            begin
                pulse_start();
            end
            delay = $urandom_range(7, 0);
            repeat (delay) @(negedge clk);
            out_ack = 1'b1;
            wait_level(SIG_OUT_REQ, 1'b0, "out_req to drop");
            out_ack = 1'b0;
        end
        wait_level(SIG_DONE, 1'b1, "done");
        repeat (5) @(negedge clk);
        check_count(name, "done pulses", 1, done_cnt - done0);
        check_count(name, "reads after unload", NREADS, rd_cyc_q.size() - rd0);
        check_flag(name, "out_req after done", 1'b0, out_req);
        report_test(name, err_before);
    endtask

    initial
    begin
        void'($urandom(95464));
        rst_n   = 1'b0;
        start   = 1'b0;
        out_ack = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        run_transform("first_run", 1'b0);
        run_transform("start_while_busy", 1'b1);
        run_transform("second_run", 1'b0);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+src
src/fft_ctrl_pkg.sv
src/fft_bfly_sequencer.sv
src/fft_desc_fifo.sv
src/fft_mem_port.sv
src/fft_unload_seq.sv
src/fft_addr_ctrl_top.sv
dv/fft_addr_ctrl_tb.sv

// File: Makefile
# Verilator build and run of the FFT address controller testbench

VERILATOR ?= verilator
TOP       ?= fft_addr_ctrl_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run, fails unless the pass message is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
